// ==== verilog/board_pkg.sv ====
`default_nettype none

package board_pkg;

    // Joystick widths on the board side and on the game side
    localparam int BOARD_JOY_W = 16;
    localparam int GAME_JOY_W  = 10;
    localparam int DIR_W       = 4;

    // Direction bit positions in every joystick word
    localparam int DIR_RIGHT = 0;
    localparam int DIR_LEFT  = 1;
    localparam int DIR_DOWN  = 2;
    localparam int DIR_UP    = 3;

    localparam int PLAYERS    = 4;
    localparam int GFX_LAYERS = 4;

    // OSD status word bits
    localparam int ST_PAUSE = 1;
    localparam int ST_NOROT = 2;
    localparam int ST_FLIP  = 3;
    localparam int ST_TEST  = 4;
    localparam int ST_NOFM  = 5;
    localparam int ST_NOPSG = 6;
    localparam int ST_FX    = 7;    // base of a 2-bit field

    // Core mode bits
    localparam int CM_VERTICAL = 0;
    localparam int CM_4WAY     = 1;

    typedef logic [BOARD_JOY_W-1:0] board_joy_t;
    typedef logic [GAME_JOY_W-1:0]  game_joy_t;

    // Levels from the keyboard decoder
    typedef struct packed {
        game_joy_t             joy1;
        game_joy_t             joy2;
        game_joy_t             joy3;
        logic [PLAYERS-1:0]    start;
        logic [PLAYERS-1:0]    coin;
        logic                  reset;
        logic                  pause;
        logic                  test;
        logic                  service;
        logic [GFX_LAYERS-1:0] gfx;
    } key_state_t;

    typedef struct packed {
        logic       rot_control;
        logic       dip_flip;
        logic       osd_pause;
        logic       dip_test;    // active low
        logic       enable_fm;
        logic       enable_psg;
        logic [1:0] fxlevel;
    } dip_cfg_t;

endpackage

`default_nettype wire

// ==== verilog/joy_4way.sv ====
`timescale 1ns/1ps
`default_nettype none

module joy_4way (
    input  wire                         rst,
    input  wire                         clk_sys,
    input  wire                         enable,
    input  wire  [board_pkg::DIR_W-1:0] joy8,
    output logic [board_pkg::DIR_W-1:0] joy4
);
    import board_pkg::*;

    // Last direction that was held on its own
    logic [DIR_W-1:0] store;
    logic [DIR_W-1:0] lowest;
    logic             single;
    logic             store_held;

    // Isolate the lowest pressed direction
    assign lowest = joy8 & (~joy8 + 1'b1);

    // Only one bit pressed when the lowest bit is all there is
    assign single = (joy8 != '0) && (lowest == joy8);

    assign store_held = |(joy8 & store);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            joy4  <= '0;
            store <= '0;
        end else if (!enable) begin
            joy4 <= joy8;
        end else if (joy8 == '0) begin
            // Stick released
            joy4  <= '0;
            store <= '0;
        end else if (single) begin
            joy4  <= joy8;
            store <= joy8;
        end else if (store_held) begin
            // Diagonal keeps the direction the player started with
            joy4 <= store;
        end else begin
            joy4 <= lowest;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/player_input.sv ====
`timescale 1ns/1ps
`default_nettype none

module player_input #(
    parameter logic INPUTS_ACTIVE_LOW = 1'b1
) (
    input  wire                         rst,
    input  wire                         clk_sys,
    input  wire                         en4way,
    input  wire  board_pkg::board_joy_t board,
    input  wire  board_pkg::game_joy_t  key_joy,
    input  wire  board_pkg::dip_cfg_t   cfg,
    output board_pkg::board_joy_t       joy_sync,
    output board_pkg::game_joy_t        game_joy
);
    import board_pkg::*;

    logic [DIR_W-1:0]             dir_filt;
    logic [BOARD_JOY_W-1:DIR_W]   joy_hi;
    game_joy_t                    joy_mix;

    // Remap directions for a monitor turned on its side
    function automatic game_joy_t rotate_joy(
        input game_joy_t joy,
        input logic      rot,
        input logic      flip
    );
        game_joy_t res;
        res = joy;
        if (rot) begin
            if (flip) begin
                res[DIR_RIGHT] = joy[DIR_DOWN];
                res[DIR_LEFT]  = joy[DIR_UP];
                res[DIR_DOWN]  = joy[DIR_RIGHT];
                res[DIR_UP]    = joy[DIR_LEFT];
            end else begin
                res[DIR_RIGHT] = joy[DIR_LEFT];
                res[DIR_LEFT]  = joy[DIR_RIGHT];
                res[DIR_DOWN]  = joy[DIR_UP];
                res[DIR_UP]    = joy[DIR_DOWN];
            end
        end
        return res;
    endfunction

    joy_4way u_4way (
        .rst     ( rst                ),
        .clk_sys ( clk_sys            ),
        .enable  ( en4way             ),
        .joy8    ( board[DIR_W-1:0]   ),
        .joy4    ( dir_filt           )
    );

    // Buttons ride along with the filtered directions
    always_ff @(posedge clk_sys) begin
        joy_hi <= board[BOARD_JOY_W-1:DIR_W];
    end

    assign joy_sync = {joy_hi, dir_filt};

    // Keyboard joystick merged before the remap
    assign joy_mix = joy_sync[GAME_JOY_W-1:0] | key_joy;

    always_ff @(posedge clk_sys) begin
        game_joy <= rotate_joy(joy_mix, cfg.rot_control, cfg.dip_flip)
                  ^ {GAME_JOY_W{INPUTS_ACTIVE_LOW}};
    end

endmodule

`default_nettype wire

// ==== verilog/dip_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module dip_decode (
    input  wire                 rst,
    input  wire                 clk_sys,
    input  wire  [31:0]         status,
    input  wire  [6:0]          core_mod,
    input  wire                 key_test,
    input  wire                 game_pause,
    output board_pkg::dip_cfg_t cfg,
    output logic                en4way,
    output logic                dip_pause,
    output logic                dip_test
);
    import board_pkg::*;

    dip_cfg_t cfg_nxt;

    always_comb begin
        // Rotation only applies to vertical games unless the OSD turns it off
        cfg_nxt.rot_control = core_mod[CM_VERTICAL] & ~status[ST_NOROT];
        cfg_nxt.dip_flip    = status[ST_FLIP];
        cfg_nxt.osd_pause   = status[ST_PAUSE];
        cfg_nxt.dip_test    = ~(status[ST_TEST] | key_test);
        cfg_nxt.enable_fm   = ~status[ST_NOFM];
        cfg_nxt.enable_psg  = ~status[ST_NOPSG];
        cfg_nxt.fxlevel     = status[ST_FX+1:ST_FX];
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            cfg.rot_control <= 1'b0;
            cfg.dip_flip    <= 1'b0;
            cfg.osd_pause   <= 1'b0;
            cfg.dip_test    <= 1'b1;
            cfg.enable_fm   <= 1'b1;
            cfg.enable_psg  <= 1'b1;
            cfg.fxlevel     <= 2'd0;
            en4way          <= 1'b0;
            dip_pause       <= 1'b1;
        end else begin
            cfg       <= cfg_nxt;
            en4way    <= core_mod[CM_4WAY];
            // Game sees pause as active low
            dip_pause <= ~game_pause;
        end
    end

    assign dip_test = cfg.dip_test;

endmodule

`default_nettype wire

// ==== verilog/board_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_ctrl #(
    parameter logic INPUTS_ACTIVE_LOW = 1'b1
) (
    input  wire                              rst,
    input  wire                              clk_sys,
    input  wire                              downloading,
    input  wire  board_pkg::key_state_t      keys,
    input  wire                              joy_pause,
    input  wire                              osd_pause,
    output logic                             game_pause,
    output logic                             soft_rst,
    output logic [board_pkg::GFX_LAYERS-1:0] gfx_en,
    output logic                             game_service
);
    import board_pkg::*;

    // Control levels that are watched for edges
    typedef struct packed {
        logic                  reset;
        logic                  pause;
        logic                  joy_pause;
        logic                  osd_pause;
        logic [GFX_LAYERS-1:0] gfx;
    } ctl_t;

    ctl_t ctl_cur;
    ctl_t ctl_q;
    ctl_t ctl_last;
    ctl_t rise;
    logic osd_change;
    logic pause_toggle;

    always_comb begin
        ctl_cur.reset     = keys.reset;
        ctl_cur.pause     = keys.pause;
        ctl_cur.joy_pause = joy_pause;
        ctl_cur.osd_pause = osd_pause;
        ctl_cur.gfx       = keys.gfx;
    end

    // Sample stage, then the previous value one cycle behind
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            ctl_q    <= '0;
            ctl_last <= '0;
        end else begin
            ctl_q    <= ctl_cur;
            ctl_last <= ctl_q;
        end
    end

    assign rise         = ctl_q & ~ctl_last;
    assign osd_change   = ctl_q.osd_pause ^ ctl_last.osd_pause;
    assign pause_toggle = rise.pause | rise.joy_pause;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_pause   <= 1'b0;
            soft_rst     <= 1'b0;
            gfx_en       <= '1;
            game_service <= INPUTS_ACTIVE_LOW;
        end else begin
            soft_rst     <= rise.reset;
            gfx_en       <= gfx_en ^ rise.gfx;
            game_service <= keys.service ^ INPUTS_ACTIVE_LOW;

            if (downloading) begin
                game_pause <= 1'b0;
            end else if (osd_change) begin
                // OSD setting wins over a toggle in the same cycle
                game_pause <= ctl_q.osd_pause;
            end else if (pause_toggle) begin
                game_pause <= ~game_pause;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/input_board.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_board #(
    parameter int   BUTTONS           = 2,
    parameter logic INPUTS_ACTIVE_LOW = 1'b1
) (
    input  wire                                               rst,
    input  wire                                               clk_sys,
    input  wire                                               downloading,
    input  wire  board_pkg::board_joy_t [board_pkg::PLAYERS-1:0] board_joy,
    input  wire  board_pkg::key_state_t                       keys,
    input  wire  [31:0]                                       status,
    input  wire  [6:0]                                        core_mod,
    output board_pkg::game_joy_t [board_pkg::PLAYERS-1:0]     game_joy,
    output logic [board_pkg::PLAYERS-1:0]                     game_coin,
    output logic [board_pkg::PLAYERS-1:0]                     game_start,
    output logic                                              game_service,
    output logic                                              game_pause,
    output logic                                              soft_rst,
    output logic                                              dip_pause,
    output logic                                              dip_test,
    output logic                                              dip_flip,
    output logic                                              enable_fm,
    output logic                                              enable_psg,
    output logic [1:0]                                        dip_fxlevel,
    output logic [board_pkg::GFX_LAYERS-1:0]                  gfx_en
);
    import board_pkg::*;

    // Button positions move up with the number of fire buttons
    localparam int START_BIT = 6 + (BUTTONS - 2);
    localparam int COIN_BIT  = 7 + (BUTTONS - 2);
    localparam int PAUSE_BIT = 8 + (BUTTONS - 2);

    dip_cfg_t                 cfg;
    logic                     en4way;
    logic                     joy_pause;
    board_joy_t [PLAYERS-1:0] joy_sync;
    game_joy_t  [PLAYERS-1:0] key_joy;
    logic       [PLAYERS-1:0] coin_bits;
    logic       [PLAYERS-1:0] start_bits;

    // Player 4 has no keyboard joystick
    assign key_joy = {{GAME_JOY_W{1'b0}}, keys.joy3, keys.joy2, keys.joy1};

    for (genvar i = 0; i < PLAYERS; i++) begin : g_player
        player_input #(
            .INPUTS_ACTIVE_LOW ( INPUTS_ACTIVE_LOW )
        ) u_player (
            .rst      ( rst          ),
            .clk_sys  ( clk_sys      ),
            .en4way   ( en4way       ),
            .board    ( board_joy[i] ),
            .key_joy  ( key_joy[i]   ),
            .cfg      ( cfg          ),
            .joy_sync ( joy_sync[i]  ),
            .game_joy ( game_joy[i]  )
        );

        assign coin_bits[i]  = joy_sync[i][COIN_BIT];
        assign start_bits[i] = joy_sync[i][START_BIT];
    end

    // Either of the first two sticks can pause
    assign joy_pause = joy_sync[0][PAUSE_BIT] | joy_sync[1][PAUSE_BIT];

    always_ff @(posedge clk_sys) begin
        game_coin  <= {PLAYERS{INPUTS_ACTIVE_LOW}} ^ (coin_bits | keys.coin);
        game_start <= {PLAYERS{INPUTS_ACTIVE_LOW}} ^ (start_bits | keys.start);
    end

    board_ctrl #(
        .INPUTS_ACTIVE_LOW ( INPUTS_ACTIVE_LOW )
    ) u_ctrl (
        .rst          ( rst           ),
        .clk_sys      ( clk_sys       ),
        .downloading  ( downloading   ),
        .keys         ( keys          ),
        .joy_pause    ( joy_pause     ),
        .osd_pause    ( cfg.osd_pause ),
        .game_pause   ( game_pause    ),
        .soft_rst     ( soft_rst      ),
        .gfx_en       ( gfx_en        ),
        .game_service ( game_service  )
    );

    dip_decode u_dip (
        .rst        ( rst        ),
        .clk_sys    ( clk_sys    ),
        .status     ( status     ),
        .core_mod   ( core_mod   ),
        .key_test   ( keys.test  ),
        .game_pause ( game_pause ),
        .cfg        ( cfg        ),
        .en4way     ( en4way     ),
        .dip_pause  ( dip_pause  ),
        .dip_test   ( dip_test   )
    );

    // Settings the core reads straight from the decoded word
    assign dip_flip    = cfg.dip_flip;
    assign enable_fm   = cfg.enable_fm;
    assign enable_psg  = cfg.enable_psg;
    assign dip_fxlevel = cfg.fxlevel;

endmodule

`default_nettype wire

// ==== tests/tb_input_board.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_input_board;
    import board_pkg::*;

    localparam int SETTLE_CYC  = 6;
    localparam int TIMEOUT_CYC = 50;
    // Stick button positions with two fire buttons
    localparam int START_BIT = 6;
    localparam int COIN_BIT  = 7;
    localparam int PAUSE_BIT = 8;
    // Random stick bits leave the pause button alone
    localparam logic [15:0] RAND_MASK = 16'hfeff;
    localparam logic [29:0] KJ = {10'h030, 10'h20a, 10'h005};

    typedef struct packed {
        board_joy_t [PLAYERS-1:0] board;
        key_state_t               keys;
        logic [31:0]              status;
        logic [6:0]               core_mod;
        logic                     dl;
        logic                     rnd;
    } step_t;

    logic                     clk_sys;
    logic                     rst;
    logic                     downloading;
    board_joy_t [PLAYERS-1:0] board_joy;
    key_state_t               keys;
    logic [31:0]              status;
    logic [6:0]               core_mod;
    game_joy_t  [PLAYERS-1:0] game_joy;
    logic [PLAYERS-1:0]       game_coin;
    logic [PLAYERS-1:0]       game_start;
    logic                     game_service;
    logic                     game_pause;
    logic                     soft_rst;
    logic                     dip_pause;
    logic                     dip_test;
    logic                     dip_flip;
    logic                     enable_fm;
    logic                     enable_psg;
    logic [1:0]               dip_fxlevel;
    logic [GFX_LAYERS-1:0]    gfx_en;

    step_t                 steps[$];
    step_t                 cur;
    step_t                 prev;
    logic [31:0]           rng;
    int                    cycle_cnt = 0;
    int                    pulses;
    int                    exp_pulses;
    // Reference model state
    logic [DIR_W-1:0]      store_ref [PLAYERS];
    logic                  pause_ref;
    logic [GFX_LAYERS-1:0] gfx_ref;
    game_joy_t             exp_joy [PLAYERS];
    logic [PLAYERS-1:0]    exp_coin;
    logic [PLAYERS-1:0]    exp_start;

    input_board #(
        .BUTTONS           ( 2    ),
        .INPUTS_ACTIVE_LOW ( 1'b1 )
    ) dut_i (
        .rst          ( rst          ),
        .clk_sys      ( clk_sys      ),
        .downloading  ( downloading  ),
        .board_joy    ( board_joy    ),
        .keys         ( keys         ),
        .status       ( status       ),
        .core_mod     ( core_mod     ),
        .game_joy     ( game_joy     ),
        .game_coin    ( game_coin    ),
        .game_start   ( game_start   ),
        .game_service ( game_service ),
        .game_pause   ( game_pause   ),
        .soft_rst     ( soft_rst     ),
        .dip_pause    ( dip_pause    ),
        .dip_test     ( dip_test     ),
        .dip_flip     ( dip_flip     ),
        .enable_fm    ( enable_fm    ),
        .enable_psg   ( enable_psg   ),
        .dip_fxlevel  ( dip_fxlevel  ),
        .gfx_en       ( gfx_en       )
    );

    always #4 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [DIR_W-1:0] lowest_dir(input logic [DIR_W-1:0] d);
        logic [DIR_W-1:0] res;
        res = '0;
        for (int b = DIR_W - 1; b >= 0; b--) begin
            if (d[b]) begin
                res    = '0;
                res[b] = 1'b1;
            end
        end
        return res;
    endfunction

    // Bits 0..3 become (left, right, up, down) or (down, up, right, left) when flipped
    function automatic game_joy_t remap(input game_joy_t v, input logic rot, input logic flip);
        if (!rot) begin
            return v;
        end
        if (flip) begin
            return {v[9:4], v[1], v[0], v[3], v[2]};
        end
        return {v[9:4], v[2], v[3], v[0], v[1]};
    endfunction

    // Key nibbles packed as kcs = {start, coin} and kctl = {reset, pause, test, service, gfx}
    task automatic add_step(input board_joy_t [PLAYERS-1:0] board, input logic [29:0] kjoy,
                            input logic [7:0] kcs, input logic [7:0] kctl,
                            input logic [31:0] st, input logic [6:0] cm, input logic [1:0] flags);
        step_t s;
        s.board        = board;
        s.keys.joy1    = kjoy[9:0];
        s.keys.joy2    = kjoy[19:10];
        s.keys.joy3    = kjoy[29:20];
        s.keys.start   = kcs[7:4];
        s.keys.coin    = kcs[3:0];
        s.keys.reset   = kctl[7];
        s.keys.pause   = kctl[6];
        s.keys.test    = kctl[5];
        s.keys.service = kctl[4];
        s.keys.gfx     = kctl[3:0];
        s.status       = st;
        s.core_mod     = cm;
        s.dl           = flags[1];
        s.rnd          = flags[0];
        steps.push_back(s);
    endtask

    task automatic build_table();
        add_step({4{16'h0000}}, 30'h0, 8'h00, 8'h00, 32'h0000, 7'h0, 2'b00);
        // Random sticks through the rotation settings
        add_step({4{16'h0000}}, KJ, 8'h00, 8'h00, 32'h0000, 7'h0, 2'b01);
        add_step({4{16'h0000}}, KJ, 8'h00, 8'h00, 32'h0000, 7'h1, 2'b01);
        add_step({4{16'h0000}}, KJ, 8'h00, 8'h00, 32'h0008, 7'h1, 2'b01);
        add_step({4{16'h0000}}, KJ, 8'h00, 8'h00, 32'h000c, 7'h1, 2'b01);
        add_step({4{16'h0000}}, KJ, 8'h00, 8'h00, 32'h01e8, 7'h1, 2'b01);
        // Coin and start from sticks and keys
        add_step({16'h0, 16'h0080, 16'h0040, 16'h0}, 30'h0, 8'h18, 8'h00, 32'h0010, 7'h0, 2'b00);
        add_step({16'h00c0, 16'h0, 16'h0, 16'h0040}, 30'h0, 8'h24, 8'h00, 32'h0000, 7'h0, 2'b00);
        // 4-way filter with a single direction, both kinds of diagonal and release
        add_step({4{16'h0008}}, 30'h0, 8'h00, 8'h00, 32'h0000, 7'h2, 2'b00);
        add_step({4{16'h0009}}, 30'h0, 8'h00, 8'h00, 32'h0000, 7'h2, 2'b00);
        add_step({4{16'h0006}}, 30'h0, 8'h00, 8'h00, 32'h0000, 7'h3, 2'b00);
        add_step({4{16'h0000}}, 30'h0, 8'h00, 8'h00, 32'h0000, 7'h2, 2'b00);
        add_step({4{16'h0005}}, 30'h0, 8'h00, 8'h00, 32'h0000, 7'h2, 2'b00);
        add_step({4{16'h0009}}, 30'h0, 8'h00, 8'h00, 32'h0000, 7'h0, 2'b00);
        // Pause toggles, OSD override and download clear
        add_step({4{16'h0000}}, 30'h0, 8'h00, 8'h40, 32'h0000, 7'h0, 2'b00);
        add_step({16'h0, 16'h0, 16'h0100, 16'h0}, 30'h0, 8'h00, 8'h00, 32'h0000, 7'h0, 2'b00);
        add_step({4{16'h0000}}, 30'h0, 8'h00, 8'h00, 32'h0002, 7'h0, 2'b00);
        add_step({4{16'h0000}}, 30'h0, 8'h00, 8'h40, 32'h0002, 7'h0, 2'b00);
        add_step({4{16'h0000}}, 30'h0, 8'h00, 8'h00, 32'h0000, 7'h0, 2'b00);
        add_step({4{16'h0000}}, 30'h0, 8'h00, 8'h40, 32'h0000, 7'h0, 2'b00);
        add_step({16'h0, 16'h0, 16'h0, 16'h0100}, 30'h0, 8'h00, 8'h40, 32'h0002, 7'h0, 2'b00);
        add_step({16'h0, 16'h0, 16'h0, 16'h0100}, 30'h0, 8'h00, 8'h40, 32'h0002, 7'h0, 2'b10);
        add_step({4{16'h0000}}, 30'h0, 8'h00, 8'h00, 32'h0000, 7'h0, 2'b00);
        // Soft reset pulses and layer toggles
        add_step({4{16'h0000}}, 30'h0, 8'h00, 8'h85, 32'h0000, 7'h0, 2'b00);
        add_step({4{16'h0000}}, 30'h0, 8'h00, 8'h87, 32'h0000, 7'h0, 2'b00);
        add_step({4{16'h0000}}, 30'h0, 8'h00, 8'h30, 32'h0000, 7'h0, 2'b00);
        add_step({4{16'h0000}}, 30'h0, 8'h00, 8'h8f, 32'h0000, 7'h0, 2'b00);
        add_step({4{16'h0000}}, 30'h0, 8'h00, 8'h00, 32'h0000, 7'h0, 2'b00);
    endtask

    task automatic predict();
        logic [DIR_W-1:0] d;
        logic [DIR_W-1:0] fdir;
        logic             rot;
        logic             en4;
        logic             upd;
        logic             key_rise;
        logic             joy_rise;
        game_joy_t        kj;
        rot = cur.core_mod[CM_VERTICAL] & ~cur.status[ST_NOROT];
        en4 = cur.core_mod[CM_4WAY];
        // Filter runs one cycle on the old enable
        upd = en4 | prev.core_mod[CM_4WAY];
        for (int i = 0; i < PLAYERS; i++) begin
            d    = cur.board[i][DIR_W-1:0];
            fdir = d;
            if (upd && d == '0) begin
                store_ref[i] = '0;
            end else if (upd && $countones(d) == 1) begin
                store_ref[i] = d;
            end
            if (en4 && $countones(d) > 1) begin
                fdir = ((d & store_ref[i]) != '0) ? store_ref[i] : lowest_dir(d);
            end
            case (i)
                0: kj = cur.keys.joy1;
                1: kj = cur.keys.joy2;
                2: kj = cur.keys.joy3;
                default: kj = '0;
            endcase
            exp_joy[i]   = ~remap({cur.board[i][9:DIR_W], fdir} | kj, rot, cur.status[ST_FLIP]);
            exp_coin[i]  = ~(cur.board[i][COIN_BIT] | cur.keys.coin[i]);
            exp_start[i] = ~(cur.board[i][START_BIT] | cur.keys.start[i]);
        end
        key_rise = cur.keys.pause & ~prev.keys.pause;
        joy_rise = (cur.board[0][PAUSE_BIT] | cur.board[1][PAUSE_BIT])
                 & ~(prev.board[0][PAUSE_BIT] | prev.board[1][PAUSE_BIT]);
        if (cur.dl) begin
            pause_ref = 1'b0;
        end else if (cur.status[ST_PAUSE] != prev.status[ST_PAUSE]) begin
            pause_ref = cur.status[ST_PAUSE];
        end else begin
            pause_ref = pause_ref ^ key_rise ^ joy_rise;
        end
        gfx_ref    = gfx_ref ^ (cur.keys.gfx & ~prev.keys.gfx);
        exp_pulses = int'(cur.keys.reset & ~prev.keys.reset);
    endtask

    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else begin
            $display("Error: time %0t, %s expected %h, actual %h", $time, name, exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic verify_outputs();
        for (int i = 0; i < PLAYERS; i++) begin
            expect_value($sformatf("game_joy[%0d]", i), 32'(exp_joy[i]), 32'(game_joy[i]));
        end
        expect_value("game_coin", 32'(exp_coin), 32'(game_coin));
        expect_value("game_start", 32'(exp_start), 32'(game_start));
        expect_value("game_service", 32'(!cur.keys.service), 32'(game_service));
        expect_value("game_pause", 32'(pause_ref), 32'(game_pause));
        expect_value("dip_pause", 32'(!pause_ref), 32'(dip_pause));
        expect_value("soft_rst pulses", 32'(exp_pulses), 32'(pulses));
        expect_value("gfx_en", 32'(gfx_ref), 32'(gfx_en));
        expect_value("dip_test", 32'(!(cur.status[ST_TEST] | cur.keys.test)), 32'(dip_test));
        expect_value("dip_flip", 32'(cur.status[ST_FLIP]), 32'(dip_flip));
        expect_value("enable_fm", 32'(!cur.status[ST_NOFM]), 32'(enable_fm));
        expect_value("enable_psg", 32'(!cur.status[ST_NOPSG]), 32'(enable_psg));
        expect_value("dip_fxlevel", 32'(cur.status[ST_FX+:2]), 32'(dip_fxlevel));
    endtask

    // Wait for a check point some clocks ahead and count soft_rst cycles
    task automatic settle(input int ncyc, output int count);
        int target;
        int guard;
        target = cycle_cnt + ncyc;
        guard  = 0;
        count  = 0;
        while (cycle_cnt < target) begin
            @(negedge clk_sys);
            guard++;
            if (soft_rst === 1'b1) begin
                count++;
            end
            if (guard > TIMEOUT_CYC) begin
                $display("Timeout: check point not reached after %0d clock edges", guard);
                $display("Test FAILED");
                $fatal(1);
            end
        end
    endtask

    initial begin
        clk_sys     = 1'b0;
        rst         = 1'b1;
        downloading = 1'b0;
        board_joy   = '0;
        keys        = '0;
        status      = '0;
        core_mod    = '0;
        rng         = 32'h9050_a85c;
        prev        = '0;
        pause_ref   = 1'b0;
        gfx_ref     = '1;
        for (int i = 0; i < PLAYERS; i++) begin
            store_ref[i] = '0;
        end
        build_table();
        settle(8, pulses);
        rst = 1'b0;
        settle(2, pulses);
        expect_value("gfx_en", 32'hf, 32'(gfx_en));
        expect_value("game_pause", 32'h0, 32'(game_pause));
        expect_value("game_service", 32'h1, 32'(game_service));
        expect_value("dip_pause", 32'h1, 32'(dip_pause));
        expect_value("soft_rst pulses", 32'h0, 32'(pulses));
        foreach (steps[s]) begin
            cur = steps[s];
            if (cur.rnd) begin
                for (int i = 0; i < PLAYERS; i++) begin
                    rng          = xorshift(rng);
                    cur.board[i] = cur.board[i] ^ (rng[15:0] & RAND_MASK);
                end
            end
            board_joy   = cur.board;
            keys        = cur.keys;
            status      = cur.status;
            core_mod    = cur.core_mod;
            downloading = cur.dl;
            predict();
            settle(SETTLE_CYC, pulses);
            verify_outputs();
            prev = cur;
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/board_pkg.sv
verilog/joy_4way.sv
verilog/player_input.sv
verilog/dip_decode.sv
verilog/board_ctrl.sv
verilog/input_board.sv
tests/tb_input_board.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the input board testbench with Verilator.
# The run passes only when the log holds the pass line.
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_input_board &&
./obj_dir/Vtb_input_board > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Test OK$" sim.log || exit 1
exit 0
